// File: mask_defs.svh
`ifndef MASK_DEFS_SVH
`define MASK_DEFS_SVH

// number of mask registers
`define MASK_NREGS 32

// width of a register number
`define MASK_ADDR_W 5

// bits held by one mask register
`define MASK_BITS 64

// bits moved per beat
`define MASK_BEAT_W 16

// beats per register, lowest beat first on every port
`define MASK_BEATS (`MASK_BITS / `MASK_BEAT_W)

// width of a beat index
`define MASK_BEAT_IDX_W 2

`endif

// File: mask_pkg.sv
`default_nettype none

`include "mask_defs.svh"

package mask_pkg;

    // register number, 0 to 31
    typedef logic [`MASK_ADDR_W-1:0] mreg_addr_t;

    // one 16-bit slice of a mask register
    typedef logic [`MASK_BEAT_W-1:0] mask_beat_t;

    // beat position inside a register
    typedef logic [`MASK_BEAT_IDX_W-1:0] beat_idx_t;

endpackage

`default_nettype wire

// File: mask_beat_if.sv
`timescale 1ns/100ps
`default_nettype none

interface mask_beat_if import mask_pkg::*; ();

    // beat access happens this cycle
    logic       en;
    // target register and beat
    mreg_addr_t reg_addr;
    beat_idx_t  beat;
    // write data, used by wr and ld only
    mask_beat_t wdata;
    // registered read data, one cycle after en
    mask_beat_t rdata;

    // port sequencer side
    modport seq (
        output en,
        output reg_addr,
        output beat,
        output wdata,
        input  rdata
    );

    // storage side
    modport bank (
        input  en,
        input  reg_addr,
        input  beat,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: mask_burst_seq.sv
`timescale 1ns/100ps
`default_nettype none

`include "mask_defs.svh"

module mask_burst_seq import mask_pkg::*; #(
    // 1 for wr/ld, 0 for rd1/rd2/st
    parameter int WRITE_PORT = 0
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    // request or write beat handshake
    input  wire logic       valid,
    output logic            ready,
    input  wire mreg_addr_t addr,
    input  wire mask_beat_t data,
    // read beat stream
    output mask_beat_t      rd_data,
    output logic            rd_valid,
    output logic            rd_last,
    // beat access to the bank
    mask_beat_if.seq        bus
);

    localparam logic IDLE = 1'b0;
    localparam logic BUSY = 1'b1;

    // last beat index of a burst
    localparam beat_idx_t LAST_BEAT = beat_idx_t'(`MASK_BEATS - 1);

    logic       state;
    // register number held for beats 1 to 3
    mreg_addr_t cur_reg;
    // next beat to access, rests at zero in IDLE
    beat_idx_t  cnt;
    // handshake completes this cycle
    logic       xfer;
    // bank access issued this cycle
    logic       step;

    // writes never stall
    // reads take a new request only once the burst has been issued
    // so the next beat 0 follows beat 3 on rd_data with no gap
    assign ready = (WRITE_PORT != 0) ? 1'b1 : (state == IDLE);

    assign xfer = valid && ready;

    // idle: start on handshake
    // busy write: one beat per transfer, gaps allowed
    // busy read: one beat every cycle
    always_comb begin
        if (state == IDLE) begin
            step = xfer;
        end else if (WRITE_PORT != 0) begin
            step = valid;
        end else begin
            step = 1'b1;
        end
    end

    // beat 0 goes straight from addr, later beats from the latch
    assign bus.en       = step;
    assign bus.reg_addr = (state == IDLE) ? addr : cur_reg;
    assign bus.beat     = cnt;

    // FSM and beat counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else if (step) begin
            if (cnt == LAST_BEAT) begin
                // burst done
                state <= IDLE;
                cnt   <= '0;
            end else begin
                state <= BUSY;
                cnt   <= cnt + 1'b1;
            end
        end
    end

    // latch register number on beat 0
    always_ff @(posedge clk) begin
        if (state == IDLE && xfer) begin
            cur_reg <= addr;
        end
    end

    // bank output is already registered
    assign rd_data = bus.rdata;

    generate
        if (WRITE_PORT != 0) begin : g_write
            // one beat straight through to the bank
            assign bus.wdata = data;
            // no read stream on a write port
            assign rd_valid  = 1'b0;
            assign rd_last   = 1'b0;
        end else begin : g_read
            logic vld_q;
            logic last_q;

            // flags ride one cycle behind the access, next to bank rdata
            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    vld_q  <= 1'b0;
                    last_q <= 1'b0;
                end else begin
                    vld_q  <= step;
                    last_q <= step && (cnt == LAST_BEAT);
                end
            end

            assign rd_valid = vld_q;
            assign rd_last  = last_q;
        end
    endgenerate

endmodule

`default_nettype wire

// File: mask_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "mask_defs.svh"

module mask_bank import mask_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    // ALU read ports
    mask_beat_if.bank rd1,
    mask_beat_if.bank rd2,
    // memory store read port
    mask_beat_if.bank st,
    // ALU write port
    mask_beat_if.bank wr,
    // memory load write port
    mask_beat_if.bank ld
);

    // 32 registers, each kept as four 16-bit beat slices
    // never cleared, unwritten registers read as X
    mask_beat_t mem [`MASK_NREGS][`MASK_BEATS];

    // ld hits the same register and beat as wr
    logic ld_drop;

    assign ld_drop = wr.en && ld.en
                  && (wr.reg_addr == ld.reg_addr)
                  && (wr.beat == ld.beat);

    // read ports
    // nonblocking, so a read sees contents from before this edge's writes

    always_ff @(posedge clk) begin
        if (rst_n && rd1.en) begin
            rd1.rdata <= mem[rd1.reg_addr][rd1.beat];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n && rd2.en) begin
            rd2.rdata <= mem[rd2.reg_addr][rd2.beat];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n && st.en) begin
            st.rdata <= mem[st.reg_addr][st.beat];
        end
    end

    // write ports
    // ALU write wins a same-beat conflict, the load beat is lost
    always_ff @(posedge clk) begin
        if (rst_n) begin
            if (wr.en) begin
                mem[wr.reg_addr][wr.beat] <= wr.wdata;
            end
            if (ld.en && !ld_drop) begin
                mem[ld.reg_addr][ld.beat] <= ld.wdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: mask_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module mask_regfile import mask_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst_n,

    // ALU read port 1
    input  wire logic       rd1_req_valid,
    output logic            rd1_req_ready,
    input  wire mreg_addr_t rd1_addr,
    output mask_beat_t      rd1_data,
    output logic            rd1_data_valid,
    output logic            rd1_data_last,

    // ALU read port 2
    input  wire logic       rd2_req_valid,
    output logic            rd2_req_ready,
    input  wire mreg_addr_t rd2_addr,
    output mask_beat_t      rd2_data,
    output logic            rd2_data_valid,
    output logic            rd2_data_last,

    // memory store port
    input  wire logic       st_req_valid,
    output logic            st_req_ready,
    input  wire mreg_addr_t st_addr,
    output mask_beat_t      st_data,
    output logic            st_data_valid,
    output logic            st_data_last,

    // ALU write port
    input  wire logic       wr_valid,
    output logic            wr_ready,
    input  wire mreg_addr_t wr_addr,
    input  wire mask_beat_t wr_data,

    // memory load port
    input  wire logic       ld_valid,
    output logic            ld_ready,
    input  wire mreg_addr_t ld_addr,
    input  wire mask_beat_t ld_data
);

    // one beat channel per port
    mask_beat_if rd1_bus ();
    mask_beat_if rd2_bus ();
    mask_beat_if st_bus ();
    mask_beat_if wr_bus ();
    mask_beat_if ld_bus ();

    // unused directions of each channel
    assign rd1_bus.wdata = '0;
    assign rd2_bus.wdata = '0;
    assign st_bus.wdata  = '0;
    assign wr_bus.rdata  = '0;
    assign ld_bus.rdata  = '0;

    // read sequencers
    mask_burst_seq #(.WRITE_PORT(0)) u_rd1_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid    (rd1_req_valid),
        .ready    (rd1_req_ready),
        .addr     (rd1_addr),
        .data     ('0),
        .rd_data  (rd1_data),
        .rd_valid (rd1_data_valid),
        .rd_last  (rd1_data_last),
        .bus      (rd1_bus.seq)
    );

    mask_burst_seq #(.WRITE_PORT(0)) u_rd2_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid    (rd2_req_valid),
        .ready    (rd2_req_ready),
        .addr     (rd2_addr),
        .data     ('0),
        .rd_data  (rd2_data),
        .rd_valid (rd2_data_valid),
        .rd_last  (rd2_data_last),
        .bus      (rd2_bus.seq)
    );

    mask_burst_seq #(.WRITE_PORT(0)) u_st_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid    (st_req_valid),
        .ready    (st_req_ready),
        .addr     (st_addr),
        .data     ('0),
        .rd_data  (st_data),
        .rd_valid (st_data_valid),
        .rd_last  (st_data_last),
        .bus      (st_bus.seq)
    );

    // write sequencers, read stream outputs unused
    mask_burst_seq #(.WRITE_PORT(1)) u_wr_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid    (wr_valid),
        .ready    (wr_ready),
        .addr     (wr_addr),
        .data     (wr_data),
        .rd_data  (),
        .rd_valid (),
        .rd_last  (),
        .bus      (wr_bus.seq)
    );

    mask_burst_seq #(.WRITE_PORT(1)) u_ld_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid    (ld_valid),
        .ready    (ld_ready),
        .addr     (ld_addr),
        .data     (ld_data),
        .rd_data  (),
        .rd_valid (),
        .rd_last  (),
        .bus      (ld_bus.seq)
    );

    // shared storage
    mask_bank u_bank (
        .clk   (clk),
        .rst_n (rst_n),
        .rd1   (rd1_bus.bank),
        .rd2   (rd2_bus.bank),
        .st    (st_bus.bank),
        .wr    (wr_bus.bank),
        .ld    (ld_bus.bank)
    );

endmodule

`default_nettype wire

// File: tb_mask_regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "mask_defs.svh"

module tb_mask_regfile import mask_pkg::*; ();

    localparam int TIMEOUT = 20;

    typedef enum int {OP_WR, OP_LD, OP_WRLD, OP_RD1, OP_RD2, OP_ST, OP_DUAL, OP_B2B} op_e;

    logic       clk;
    logic       rst_n;
    // read ports by index: 0 rd1, 1 rd2, 2 st
    logic [2:0] rq_valid;
    logic [2:0] rq_ready;
    mreg_addr_t rq_addr [3];
    mask_beat_t rd_data [3];
    logic [2:0] rd_valid;
    logic [2:0] rd_last;
    logic       wr_valid;
    logic       wr_ready;
    mreg_addr_t wr_addr;
    mask_beat_t wr_data;
    logic       ld_valid;
    logic       ld_ready;
    mreg_addr_t ld_addr;
    mask_beat_t ld_data;

    // reference contents, same wr-over-ld rule
    logic [63:0] model [`MASK_NREGS];
    logic [63:0] got [3];
    logic [31:0] lfsr;
    int          err_count;
    string       cur_name;

    // stimulus table
    string       t_name [$];
    op_e         t_op [$];
    mreg_addr_t  t_ra [$];
    mreg_addr_t  t_rb [$];
    logic [63:0] t_da [$];
    logic [63:0] t_db [$];
    logic        t_gap [$];

    mask_regfile DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd1_req_valid  (rq_valid[0]),
        .rd1_req_ready  (rq_ready[0]),
        .rd1_addr       (rq_addr[0]),
        .rd1_data       (rd_data[0]),
        .rd1_data_valid (rd_valid[0]),
        .rd1_data_last  (rd_last[0]),
        .rd2_req_valid  (rq_valid[1]),
        .rd2_req_ready  (rq_ready[1]),
        .rd2_addr       (rq_addr[1]),
        .rd2_data       (rd_data[1]),
        .rd2_data_valid (rd_valid[1]),
        .rd2_data_last  (rd_last[1]),
        .st_req_valid   (rq_valid[2]),
        .st_req_ready   (rq_ready[2]),
        .st_addr        (rq_addr[2]),
        .st_data        (rd_data[2]),
        .st_data_valid  (rd_valid[2]),
        .st_data_last   (rd_last[2]),
        .wr_valid       (wr_valid),
        .wr_ready       (wr_ready),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .ld_valid       (ld_valid),
        .ld_ready       (ld_ready),
        .ld_addr        (ld_addr),
        .ld_data        (ld_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // inputs change 1 ns after the edge, outputs are settled there too
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_name, what, exp, act);
            err_count++;
        end
    endtask

    // right shift Galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic add_test(input string n, input op_e op, input mreg_addr_t ra,
                            input mreg_addr_t rb, input logic [63:0] da,
                            input logic [63:0] db, input logic gap);
        t_name.push_back(n);
        t_op.push_back(op);
        t_ra.push_back(ra);
        t_rb.push_back(rb);
        t_da.push_back(da);
        t_db.push_back(db);
        t_gap.push_back(gap);
    endtask

    // one burst on wr, ld or both in lockstep
    task automatic write_burst(input logic do_wr, input logic do_ld, input mreg_addr_t aw,
                               input mreg_addr_t al, input logic [63:0] dw,
                               input logic [63:0] dl, input logic gap);
        int t;
        for (int k = 0; k < 4; k++) begin
            wr_valid = do_wr;
            ld_valid = do_ld;
            // address only counts on beat 0, scramble it later when gapped
            wr_addr = (k != 0 && gap) ? ~aw : aw;
            ld_addr = (k != 0 && gap) ? ~al : al;
            wr_data = dw[k*16 +: 16];
            ld_data = dl[k*16 +: 16];
            t = 0;
            while ((do_wr && !wr_ready) || (do_ld && !ld_ready)) begin
                if (t == TIMEOUT) begin
                    $display("%s: write port never became ready", cur_name);
                    err_count++;
                    wr_valid = 1'b0;
                    ld_valid = 1'b0;
                    return;
                end
                tick();
                t++;
            end
            tick();
            wr_valid = 1'b0;
            ld_valid = 1'b0;
            if (gap) begin
                wr_data = ~wr_data;
                tick();
                tick();
            end
        end
        // ld first so a same-register wr overrides it
        if (do_ld) model[al] = dl;
        if (do_wr) model[aw] = dw;
    endtask

    // parallel request on the selected read ports, beats collected into got
    task automatic read_ports(input logic [2:0] sel);
        int t;
        for (int p = 0; p < 3; p++) begin
            rq_valid[p] = sel[p];
            got[p] = 'x;
        end
        t = 0;
        while ((rq_ready & sel) != sel) begin
            if (t == TIMEOUT) begin
                $display("%s: read request was never accepted", cur_name);
                err_count++;
                rq_valid = '0;
                return;
            end
            tick();
            t++;
        end
        tick();
        rq_valid = '0;
        // beat k shows in the k-th cycle after acceptance
        for (int k = 0; k < 4; k++) begin
            for (int p = 0; p < 3; p++) begin
                if (sel[p]) begin
                    check($sformatf("port%0d valid beat%0d", p, k), 64'(1), 64'(rd_valid[p]));
                    check($sformatf("port%0d last beat%0d", p, k), 64'(k == 3), 64'(rd_last[p]));
                    got[p][k*16 +: 16] = rd_data[p];
                end
            end
            tick();
        end
    endtask

    // rd1 held valid across two bursts, the second request waits on ready
    task automatic b2b_read(input mreg_addr_t ra, input mreg_addr_t rb);
        int t;
        rq_addr[0] = ra;
        rq_valid[0] = 1'b1;
        t = 0;
        while (!rq_ready[0]) begin
            if (t == TIMEOUT) begin
                $display("%s: first rd1 request was never accepted", cur_name);
                err_count++;
                rq_valid[0] = 1'b0;
                return;
            end
            tick();
            t++;
        end
        tick();
        rq_addr[0] = rb;
        for (int c = 0; c < 8; c++) begin
            // ready low for three busy cycles, back in the cycle of beat 3
            check($sformatf("ready cycle%0d", c), 64'(c % 4 == 3), 64'(rq_ready[0]));
            check($sformatf("valid cycle%0d", c), 64'(1), 64'(rd_valid[0]));
            check($sformatf("last cycle%0d", c), 64'(c % 4 == 3), 64'(rd_last[0]));
            got[c / 4][(c % 4)*16 +: 16] = rd_data[0];
            tick();
            if (c == 3) rq_valid[0] = 1'b0;
        end
        check("valid after bursts", 64'(0), 64'(rd_valid[0]));
    endtask

    task automatic build_table();
        logic [63:0] r;
        logic [63:0] d;
        add_test("wr_then_rd1", OP_WR, 5'd3, 5'd0, 64'h0123_4567_89ab_cdef, '0, 1'b0);
        add_test("rd1_after_wr", OP_RD1, 5'd3, 5'd0, '0, '0, 1'b0);
        add_test("ld_burst", OP_LD, 5'd7, 5'd0, 64'hfeed_0bad_c0de_5a5a, '0, 1'b0);
        add_test("st_after_ld", OP_ST, 5'd7, 5'd0, '0, '0, 1'b0);
        add_test("st_after_wr", OP_ST, 5'd3, 5'd0, '0, '0, 1'b0);
        add_test("wr_reg10", OP_WR, 5'd10, 5'd0, 64'h1111_2222_3333_4444, '0, 1'b0);
        add_test("wr_reg11", OP_WR, 5'd11, 5'd0, 64'haaaa_bbbb_cccc_dddd, '0, 1'b0);
        add_test("dual_read", OP_DUAL, 5'd10, 5'd11, '0, '0, 1'b0);
        add_test("rd1_back_to_back", OP_B2B, 5'd11, 5'd10, '0, '0, 1'b0);
        add_test("conflict_same", OP_WRLD, 5'd20, 5'd20, 64'h600d_600d_600d_600d,
                 64'hbad0_bad0_bad0_bad0, 1'b0);
        add_test("rd2_conflict", OP_RD2, 5'd20, 5'd0, '0, '0, 1'b0);
        add_test("wr_ld_split", OP_WRLD, 5'd21, 5'd22, 64'h0f0f_f0f0_0f0f_f0f0,
                 64'h3c3c_c3c3_5555_aaaa, 1'b0);
        add_test("rd1_split_wr", OP_RD1, 5'd21, 5'd0, '0, '0, 1'b0);
        add_test("st_split_ld", OP_ST, 5'd22, 5'd0, '0, '0, 1'b0);
        add_test("wr_gapped", OP_WR, 5'd25, 5'd0, 64'hdead_beef_cafe_f00d, '0, 1'b1);
        add_test("rd1_gapped", OP_RD1, 5'd25, 5'd0, '0, '0, 1'b0);
        // random sweep, each write read back on all three ports
        for (int i = 0; i < 8; i++) begin
            take_bits(1, r);
            take_bits(64, d);
            add_test($sformatf("rand%0d_write", i), r[0] ? OP_LD : OP_WR, 5'd0, 5'd0, d, '0,
                     1'b0);
            take_bits(5, r);
            t_ra[t_ra.size()-1] = r[4:0];
            add_test($sformatf("rand%0d_rd1", i), OP_RD1, r[4:0], 5'd0, '0, '0, 1'b0);
            add_test($sformatf("rand%0d_rd2", i), OP_RD2, r[4:0], 5'd0, '0, '0, 1'b0);
            add_test($sformatf("rand%0d_st", i), OP_ST, r[4:0], 5'd0, '0, '0, 1'b0);
        end
    endtask

    initial begin
        int e0;
        int p;
        int n_pass;
        int n_fail;
        logic [63:0] exp_a;
        logic [63:0] exp_b;
        rst_n = 1'b0;
        rq_valid = '0;
        for (int i = 0; i < 3; i++) rq_addr[i] = '0;
        wr_valid = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        ld_valid = 1'b0;
        ld_addr = '0;
        ld_data = '0;
        lfsr = 32'h6673;
        err_count = 0;
        n_pass = 0;
        n_fail = 0;
        build_table();
        repeat (3) tick();
        rst_n = 1'b1;

        // idle outputs straight after reset
        cur_name = "reset_state";
        check("req_ready", 64'(3'b111), 64'(rq_ready));
        check("data_valid", 64'(0), 64'(rd_valid));
        check("data_last", 64'(0), 64'(rd_last));
        check("write ready", 64'(2'b11), 64'({wr_ready, ld_ready}));
        if (err_count == 0) n_pass++;
        else n_fail++;
        $display("test %s: %0d errors", cur_name, err_count);

        for (int i = 0; i < t_name.size(); i++) begin
            cur_name = t_name[i];
            e0 = err_count;
            case (t_op[i])
                OP_WR:   write_burst(1'b1, 1'b0, t_ra[i], 5'd0, t_da[i], '0, t_gap[i]);
                OP_LD:   write_burst(1'b0, 1'b1, 5'd0, t_ra[i], '0, t_da[i], t_gap[i]);
                OP_WRLD: write_burst(1'b1, 1'b1, t_ra[i], t_rb[i], t_da[i], t_db[i], 1'b0);
                OP_DUAL: begin
                    exp_a = model[t_ra[i]];
                    exp_b = model[t_rb[i]];
                    rq_addr[0] = t_ra[i];
                    rq_addr[1] = t_rb[i];
                    read_ports(3'b011);
                    check("rd1 data", exp_a, got[0]);
                    check("rd2 data", exp_b, got[1]);
                end
                OP_B2B: begin
                    exp_a = model[t_ra[i]];
                    exp_b = model[t_rb[i]];
                    b2b_read(t_ra[i], t_rb[i]);
                    check("first burst", exp_a, got[0]);
                    check("second burst", exp_b, got[1]);
                end
                default: begin
                    p = int'(t_op[i]) - int'(OP_RD1);
                    exp_a = model[t_ra[i]];
                    rq_addr[p] = t_ra[i];
                    read_ports(3'(1 << p));
                    check("data", exp_a, got[p]);
                end
            endcase
            if (err_count == e0) n_pass++;
            else n_fail++;
            $display("test %s: %0d errors", cur_name, err_count - e0);
        end

        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0 && err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
mask_pkg.sv
mask_beat_if.sv
mask_burst_seq.sv
mask_bank.sv
mask_regfile.sv
tb_mask_regfile.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_mask_regfile
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a failing log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
